// ==== design/mem_types_pkg.sv ====
// commands carry word-aligned addresses and 32-bit words; mask bit n enables byte n
package mem_types_pkg;

    typedef logic [31:0] mem_addr_t;   // byte address
    typedef logic [31:0] mem_word_t;
    typedef logic [3:0]  byte_mask_t;  // bit n enables byte n

    typedef enum logic [1:0] {
        OP_NONE    = 2'd0,
        OP_READ    = 2'd1,
        OP_WRITE   = 2'd2,
        OP_REFRESH = 2'd3
    } mem_op_t;

    // one command as a peer holds it toward the memory
    typedef struct packed {
        mem_op_t    op;
        mem_addr_t  addr;    // word aligned
        mem_word_t  wdata;
        byte_mask_t mask;
    } mem_cmd_t;

    // nothing requested
    localparam mem_cmd_t CMD_IDLE = '{
        op:    OP_NONE,
        addr:  '0,
        wdata: '0,
        mask:  '0
    };

endpackage

// ==== design/lsu_types_pkg.sv ====
// size and sign fields follow the core's funct3 layout; size value 3 is handled as a word
package lsu_types_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE     = 2'd0,
        SIZE_HALF     = 2'd1,
        SIZE_WORD     = 2'd2,
        SIZE_WORD_ALT = 2'd3   // treated as a word
    } access_size_t;

    // funct3: bit 2 selects zero extension on loads
    typedef struct packed {
        logic         unsigned_load;
        access_size_t size;
    } access_ctrl_t;

    typedef enum logic [3:0] {
        ST_IDLE        = 4'd0,
        ST_FIRST_REQ   = 4'd1,   // first word command raised
        ST_FIRST_WAIT  = 4'd2,
        ST_SECOND_REQ  = 4'd3,   // word at address plus 4
        ST_SECOND_WAIT = 4'd4
    } lsu_state_t;

endpackage

// ==== design/unaligned_lsu.sv ====
// one access at a time; boundary-crossing accesses become two word commands, no misalign trap
module unaligned_lsu
    import mem_types_pkg::*, lsu_types_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  logic         i_rd_en,
    input  logic         i_wr_en,
    input  mem_addr_t    i_addr,
    input  mem_word_t    i_wdata,
    input  access_ctrl_t i_ctrl,
    output mem_word_t    o_rdata,
    output logic         o_busy,
    output mem_cmd_t     o_cmd,
    input  logic         i_mem_busy,
    input  mem_word_t    i_mem_rdata
);

    lsu_state_t   r_state;
    mem_op_t      r_op;          // op of the command on o_cmd
    mem_addr_t    r_maddr;
    mem_word_t    r_mdata;
    byte_mask_t   r_mmask;
    mem_word_t    r_wdata_hi;    // second word of a split store
    byte_mask_t   r_mask_hi;
    logic         r_is_read;
    logic         r_two;         // access crosses a word boundary

    // load view, kept until the next accepted load
    logic [1:0]   r_ld_off;
    access_ctrl_t r_ld_ctrl;
    mem_word_t    r_lo;
    logic [23:0]  r_hi;          // only three bytes of the upper word can be needed

    logic [1:0]   w_off;
    logic         w_start;
    logic         w_two;
    mem_word_t    w_store;
    byte_mask_t   w_size_mask;
    logic [63:0]  w_wide_data;
    logic [7:0]   w_wide_mask;
    logic [55:0]  w_pair;
    mem_word_t    w_shifted;

    assign w_off   = i_addr[1:0];
    assign w_start = (r_state == ST_IDLE) && (i_rd_en || i_wr_en);

    // request decode
    always_comb begin
        case (i_ctrl.size)
            SIZE_BYTE: begin
                w_two       = 1'b0;
                w_store     = {24'h0, i_wdata[7:0]};
                w_size_mask = 4'b0001;
            end
            SIZE_HALF: begin
                w_two       = (w_off == 2'd3);
                w_store     = {16'h0, i_wdata[15:0]};
                w_size_mask = 4'b0011;
            end
            SIZE_WORD, SIZE_WORD_ALT: begin
                w_two       = (w_off != 2'd0);
                w_store     = i_wdata;
                w_size_mask = 4'b1111;
            end
        endcase
    end

    // low half goes to the first word, high half to the next one
    assign w_wide_data = {32'h0, w_store} << {w_off, 3'b000};
    assign w_wide_mask = {4'h0, w_size_mask} << w_off;

    // gathered load bytes, shifted down to bit 0
    assign w_pair    = {r_hi, r_lo} >> {r_ld_off, 3'b000};
    assign w_shifted = w_pair[31:0];

    always_comb begin
        case (r_ld_ctrl.size)
            SIZE_BYTE: begin
                if (r_ld_ctrl.unsigned_load) begin
                    o_rdata = {24'h0, w_shifted[7:0]};
                end else begin
                    o_rdata = {{24{w_shifted[7]}}, w_shifted[7:0]};
                end
            end
            SIZE_HALF: begin
                if (r_ld_ctrl.unsigned_load) begin
                    o_rdata = {16'h0, w_shifted[15:0]};
                end else begin
                    o_rdata = {{16{w_shifted[15]}}, w_shifted[15:0]};
                end
            end
            SIZE_WORD, SIZE_WORD_ALT: o_rdata = w_shifted;
        endcase
    end

    assign o_busy = (r_state != ST_IDLE);
    assign o_cmd  = '{op: r_op, addr: r_maddr, wdata: r_mdata, mask: r_mmask};

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_state <= ST_IDLE;
            r_op    <= OP_NONE;
        end else begin
            case (r_state)
                ST_IDLE: begin
                    if (w_start) begin
                        r_is_read <= i_rd_en;   // read wins if both are raised
                        r_two     <= w_two;
                        r_maddr   <= {i_addr[31:2], 2'b00};
                        r_state   <= ST_FIRST_REQ;
                        if (i_rd_en) begin
                            r_op       <= OP_READ;
                            r_mdata    <= '0;
                            r_mmask    <= '0;
                            r_wdata_hi <= '0;
                            r_mask_hi  <= '0;
                            r_ld_off   <= w_off;
                            r_ld_ctrl  <= i_ctrl;
                        end else begin
                            r_op       <= OP_WRITE;
                            r_mdata    <= w_wide_data[31:0];
                            r_mmask    <= w_wide_mask[3:0];
                            r_wdata_hi <= w_wide_data[63:32];
                            r_mask_hi  <= w_wide_mask[7:4];
                        end
                    end
                end
                ST_FIRST_REQ: begin
                    if (i_mem_busy) begin   // accepted, drop the command
                        r_op    <= OP_NONE;
                        r_state <= ST_FIRST_WAIT;
                    end
                end
                ST_FIRST_WAIT: begin
                    if (!i_mem_busy) begin
                        if (r_is_read) begin
                            r_lo <= i_mem_rdata;
                        end
                        if (r_two) begin
                            r_op    <= r_is_read ? OP_READ : OP_WRITE;
                            r_maddr <= r_maddr + 32'd4;
                            r_mdata <= r_wdata_hi;
                            r_mmask <= r_mask_hi;
                            r_state <= ST_SECOND_REQ;
                        end else begin
                            r_state <= ST_IDLE;
                        end
                    end
                end
                ST_SECOND_REQ: begin
                    if (i_mem_busy) begin
                        r_op    <= OP_NONE;
                        r_state <= ST_SECOND_WAIT;
                    end
                end
                ST_SECOND_WAIT: begin
                    if (!i_mem_busy) begin
                        if (r_is_read) begin
                            r_hi <= i_mem_rdata[23:0];
                        end
                        r_state <= ST_IDLE;
                    end
                end
                default: begin
                    r_op    <= OP_NONE;
                    r_state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/refresh_timer.sv ====
// fixed interval; a refresh held off by other traffic is served late but never skipped
module refresh_timer
    import mem_types_pkg::*;
#(
    parameter int REFRESH_INTERVAL = 60
) (
    input  logic     clk,
    input  logic     i_rst_n,
    output mem_cmd_t o_cmd,
    input  logic     i_busy
);

    localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);

    typedef logic [CNT_W-1:0] ref_count_t;

    typedef enum logic [1:0] {
        RT_COUNT = 2'd0,
        RT_REQ   = 2'd1,   // refresh raised, waiting for busy
        RT_WAIT  = 2'd2    // accepted, waiting for busy to fall
    } rt_state_t;

    rt_state_t  r_state;
    ref_count_t r_count;
    logic       w_due;

    assign w_due = (r_count == ref_count_t'(REFRESH_INTERVAL));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_state <= RT_COUNT;
            r_count <= '0;
        end else begin
            if (!w_due) begin
                r_count <= r_count + 1'b1;   // holds at the interval
            end
            case (r_state)
                RT_COUNT: if (w_due) r_state <= RT_REQ;
                RT_REQ:   if (i_busy) r_state <= RT_WAIT;
                RT_WAIT: begin
                    if (!i_busy) begin
                        r_count <= '0;   // restart once the refresh is done
                        r_state <= RT_COUNT;
                    end
                end
                default: r_state <= RT_COUNT;
            endcase
        end
    end

    always_comb begin
        o_cmd = CMD_IDLE;
        if (r_state == RT_REQ) begin
            o_cmd.op = OP_REFRESH;
        end
    end

endmodule

// ==== design/mem_arbiter.sv ====
// two peers with refresh first; a grant covers one whole memory transaction
module mem_arbiter
    import mem_types_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,
    input  mem_cmd_t i_lsu_cmd,
    input  mem_cmd_t i_ref_cmd,
    output logic     o_lsu_busy,
    output logic     o_ref_busy,
    output mem_cmd_t o_mem_cmd,
    input  logic     i_mem_busy
);

    typedef enum logic [1:0] {
        OWN_NONE = 2'd0,
        OWN_LSU  = 2'd1,
        OWN_REF  = 2'd2
    } owner_t;

    owner_t r_owner;
    logic   r_seen_busy;   // memory has gone busy for this grant
    owner_t w_pick;
    owner_t w_grant;

    // new grant only while idle and the memory is free
    always_comb begin
        w_pick = OWN_NONE;
        if (r_owner == OWN_NONE && !i_mem_busy) begin
            if (i_ref_cmd.op != OP_NONE) begin
                w_pick = OWN_REF;   // refresh wins ties
            end else if (i_lsu_cmd.op != OP_NONE) begin
                w_pick = OWN_LSU;
            end
        end
    end

    // forward in the same cycle as the pick
    assign w_grant = (r_owner != OWN_NONE) ? r_owner : w_pick;

    always_comb begin
        case (w_grant)
            OWN_LSU: o_mem_cmd = i_lsu_cmd;
            OWN_REF: o_mem_cmd = i_ref_cmd;
            default: o_mem_cmd = CMD_IDLE;
        endcase
    end

    // a waiting peer sees busy low, so it keeps its command raised until its turn
    assign o_lsu_busy = (w_grant == OWN_LSU) && i_mem_busy;
    assign o_ref_busy = (w_grant == OWN_REF) && i_mem_busy;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_owner     <= OWN_NONE;
            r_seen_busy <= 1'b0;
        end else if (r_owner == OWN_NONE) begin
            r_owner     <= w_pick;
            r_seen_busy <= 1'b0;
        end else if (i_mem_busy) begin
            r_seen_busy <= 1'b1;
        end else if (r_seen_busy) begin
            r_owner <= OWN_NONE;   // busy fell, transaction over
        end
    end

endmodule

// ==== design/word_mem_ctrl.sv ====
// behavioral SDRAM stand-in: no pins or init sequence, fixed latency, contents start at zero
module word_mem_ctrl
    import mem_types_pkg::*;
#(
    parameter int MEM_WORDS      = 256,
    parameter int MEM_LATENCY    = 3,   // at least 1
    parameter int REFRESH_CYCLES = 5    // at least 1
) (
    input  logic      clk,
    input  logic      i_rst_n,
    input  mem_cmd_t  i_cmd,
    output logic      o_busy,
    output mem_word_t o_rdata
);

    localparam int IDX_W   = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int MAX_CYC = (MEM_LATENCY > REFRESH_CYCLES) ? MEM_LATENCY : REFRESH_CYCLES;
    localparam int CNT_W   = $clog2(MAX_CYC + 1);

    typedef logic [IDX_W-1:0] word_idx_t;
    typedef logic [CNT_W-1:0] busy_count_t;

    mem_word_t   r_mem [MEM_WORDS] = '{default: '0};
    mem_word_t   r_rdata;
    logic        r_busy;
    busy_count_t r_count;   // busy cycles left after this one
    word_idx_t   w_idx;
    logic        w_take;

    // word index wraps at the memory depth
    assign w_idx  = word_idx_t'(i_cmd.addr[31:2] % 30'(MEM_WORDS));
    assign w_take = !r_busy && (i_cmd.op != OP_NONE);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_busy  <= 1'b0;
            r_count <= '0;
        end else if (w_take) begin
            r_busy <= 1'b1;
            if (i_cmd.op == OP_REFRESH) begin
                r_count <= busy_count_t'(REFRESH_CYCLES - 1);
            end else begin
                r_count <= busy_count_t'(MEM_LATENCY - 1);
            end
        end else if (r_busy) begin
            if (r_count == '0) begin
                r_busy <= 1'b0;
            end else begin
                r_count <= r_count - 1'b1;
            end
        end
    end

    // array access happens when the command is taken; refresh touches no data
    always_ff @(posedge clk) begin
        if (w_take && i_cmd.op == OP_WRITE) begin
            for (int b = 0; b < 4; b++) begin
                if (i_cmd.mask[b]) begin
                    r_mem[w_idx][8*b +: 8] <= i_cmd.wdata[8*b +: 8];
                end
            end
        end
        if (w_take && i_cmd.op == OP_READ) begin
            r_rdata <= r_mem[w_idx];   // ready long before busy falls
        end
    end

    assign o_busy  = r_busy;
    assign o_rdata = r_rdata;

endmodule

// ==== design/mem_subsystem_top.sv ====
// single clock, synchronous reset; the parameters here set every block below
module mem_subsystem_top
    import mem_types_pkg::*, lsu_types_pkg::*;
#(
    parameter int MEM_WORDS        = 256,
    parameter int MEM_LATENCY      = 3,
    parameter int REFRESH_CYCLES   = 5,
    parameter int REFRESH_INTERVAL = 60
) (
    input  logic         clk,
    input  logic         i_rst_n,
    input  logic         i_rd_en,
    input  logic         i_wr_en,
    input  mem_addr_t    i_addr,
    input  mem_word_t    i_wdata,
    input  access_ctrl_t i_ctrl,
    output mem_word_t    o_rdata,
    output logic         o_busy
);

    mem_cmd_t  lsu_cmd;
    mem_cmd_t  ref_cmd;
    mem_cmd_t  mem_cmd;
    logic      lsu_busy;
    logic      ref_busy;
    logic      mem_busy;
    mem_word_t mem_rdata;   // shared read word, only the lsu reads it

    unaligned_lsu lsu0 (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_rd_en(i_rd_en), .i_wr_en(i_wr_en), .i_addr(i_addr), .i_wdata(i_wdata),
        .i_ctrl(i_ctrl), .o_rdata(o_rdata), .o_busy(o_busy),
        .o_cmd(lsu_cmd), .i_mem_busy(lsu_busy), .i_mem_rdata(mem_rdata)
    );

    refresh_timer #(.REFRESH_INTERVAL(REFRESH_INTERVAL)) rfr0 (
        .clk(clk), .i_rst_n(i_rst_n), .o_cmd(ref_cmd), .i_busy(ref_busy)
    );

    mem_arbiter arb0 (
        .clk(clk), .i_rst_n(i_rst_n), .i_lsu_cmd(lsu_cmd), .i_ref_cmd(ref_cmd),
        .o_lsu_busy(lsu_busy), .o_ref_busy(ref_busy),
        .o_mem_cmd(mem_cmd), .i_mem_busy(mem_busy)
    );

    word_mem_ctrl #(
        .MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY), .REFRESH_CYCLES(REFRESH_CYCLES)
    ) mem0 (
        .clk(clk), .i_rst_n(i_rst_n), .i_cmd(mem_cmd), .o_busy(mem_busy), .o_rdata(mem_rdata)
    );

endmodule

// ==== testbench/tb_mem_subsystem.sv ====
// default parameters only; memory starts at zero and load values are fixed by the store rows
module tb_mem_subsystem
    import mem_types_pkg::*, lsu_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam access_ctrl_t LB     = '{unsigned_load: 1'b0, size: SIZE_BYTE};
    localparam access_ctrl_t LBU    = '{unsigned_load: 1'b1, size: SIZE_BYTE};
    localparam access_ctrl_t LH     = '{unsigned_load: 1'b0, size: SIZE_HALF};
    localparam access_ctrl_t LHU    = '{unsigned_load: 1'b1, size: SIZE_HALF};
    localparam access_ctrl_t LW     = '{unsigned_load: 1'b0, size: SIZE_WORD};
    localparam access_ctrl_t LW_ALT = '{unsigned_load: 1'b0, size: SIZE_WORD_ALT};

    // one access of the table
    typedef struct packed {
        logic         wr;
        mem_addr_t    addr;
        access_ctrl_t ctrl;
        mem_word_t    wdata;
        mem_word_t    expected;   // loads only
    } row_t;

    logic         clk;
    logic         i_rst_n;
    logic         i_rd_en;
    logic         i_wr_en;
    mem_addr_t    i_addr;
    mem_word_t    i_wdata;
    access_ctrl_t i_ctrl;
    mem_word_t    o_rdata;
    logic         o_busy;

    row_t rows[$];
    int   errors      = 0;
    int   cycle_count = 0;
    int   cycle_limit = 0;

    mem_subsystem_top dut0 (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_rd_en(i_rd_en), .i_wr_en(i_wr_en), .i_addr(i_addr), .i_wdata(i_wdata),
        .i_ctrl(i_ctrl), .o_rdata(o_rdata), .o_busy(o_busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic store_row(input mem_addr_t addr, input access_ctrl_t ctrl,
                             input mem_word_t data);
        rows.push_back('{1'b1, addr, ctrl, data, 32'h0});
    endtask

    task automatic load_row(input mem_addr_t addr, input access_ctrl_t ctrl,
                            input mem_word_t expected);
        rows.push_back('{1'b0, addr, ctrl, 32'h0, expected});
    endtask

    // little-endian bytes, untouched memory reads as zero
    task automatic build_table();
        store_row(32'h000, LW, 32'h807F_A53C);   // bytes 3c a5 7f 80
        load_row (32'h000, LW, 32'h807F_A53C);
        load_row (32'h000, LB, 32'h0000_003C);
        load_row (32'h001, LB, 32'hFFFF_FFA5);
        load_row (32'h001, LBU, 32'h0000_00A5);
        load_row (32'h003, LB, 32'hFFFF_FF80);
        load_row (32'h000, LH, 32'hFFFF_A53C);
        load_row (32'h000, LHU, 32'h0000_A53C);
        load_row (32'h002, LH, 32'hFFFF_807F);
        load_row (32'h001, LH, 32'h0000_7FA5);
        // sub-word stores inside one word
        store_row(32'h010, LW, 32'h1122_3344);
        store_row(32'h011, LB, 32'h5555_55EE);   // upper data bits ignored
        store_row(32'h012, LH, 32'h9999_7766);
        load_row (32'h010, LW, 32'h7766_EE44);
        store_row(32'h010, LB, 32'h0000_0001);
        load_row (32'h010, LW, 32'h7766_EE01);
        load_row (32'h012, LW_ALT, 32'h0000_7766);   // size 3 split into the zero word 0x14
        // split stores across a word boundary
        store_row(32'h020, LW, 32'hAAAA_AAAA);
        store_row(32'h024, LW, 32'hBBBB_BBBB);
        store_row(32'h023, LH, 32'h0000_1234);
        load_row (32'h020, LW, 32'h34AA_AAAA);
        load_row (32'h024, LW, 32'hBBBB_BB12);
        store_row(32'h029, LW, 32'h0102_0304);
        load_row (32'h028, LW, 32'h0203_0400);
        load_row (32'h02C, LW, 32'h0000_0001);
        store_row(32'h032, LW, 32'hCAFE_F00D);
        load_row (32'h030, LW, 32'hF00D_0000);
        load_row (32'h034, LW, 32'h0000_CAFE);
        store_row(32'h03B, LW, 32'h89AB_CDEF);
        load_row (32'h038, LW, 32'hEF00_0000);
        load_row (32'h03C, LW, 32'h0089_ABCD);
        // split loads
        load_row (32'h029, LW, 32'h0102_0304);
        load_row (32'h032, LW, 32'hCAFE_F00D);
        load_row (32'h03B, LW, 32'h89AB_CDEF);
        load_row (32'h023, LH, 32'h0000_1234);
        load_row (32'h03B, LHU, 32'h0000_CDEF);
        load_row (32'h03B, LH, 32'hFFFF_CDEF);
        load_row (32'h027, LW, 32'h0304_00BB);   // top byte of 0x24 plus 0x28
    endtask

    // one-cycle request on the falling edge, then wait for the access to end
    task automatic run_access(input row_t r);
        while (o_busy) @(negedge clk);
        i_addr  = r.addr;
        i_wdata = r.wdata;
        i_ctrl  = r.ctrl;
        i_wr_en = r.wr;
        i_rd_en = !r.wr;
        @(negedge clk);
        i_rd_en = 1'b0;
        i_wr_en = 1'b0;
        while (o_busy) @(negedge clk);
    endtask

    task automatic check_load(input row_t r, input int idx);
        assert (o_rdata === r.expected) else begin
            errors++;
            $display("** Error: row %0d addr %h o_rdata expected %h actual %h",
                     idx, r.addr, r.expected, o_rdata);
        end
    endtask

    // watchdog over the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: accesses still not done after %0d cycles", cycle_limit);
            $display("errors: %0d of %0d rows checked, run aborted", errors, rows.size());
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        i_rst_n = 1'b0;
        i_rd_en = 1'b0;
        i_wr_en = 1'b0;
        i_addr  = '0;
        i_wdata = '0;
        i_ctrl  = LW;
        build_table();
        cycle_limit = 40 * rows.size() + 8;
        repeat (8) @(negedge clk);
        i_rst_n = 1'b1;
        @(negedge clk);
        assert (o_busy === 1'b0) else begin
            errors++;
            $display("** Error: o_busy after reset expected %h actual %h", 1'b0, o_busy);
        end
        foreach (rows[i]) begin
            run_access(rows[i]);
            if (!rows[i].wr) begin
                check_load(rows[i], i);
            end
        end
        $display("errors: %0d over %0d rows", errors, rows.size());
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
design/mem_types_pkg.sv
design/lsu_types_pkg.sv
design/unaligned_lsu.sv
design/refresh_timer.sv
design/mem_arbiter.sv
design/word_mem_ctrl.sv
design/mem_subsystem_top.sv
testbench/tb_mem_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mem_subsystem
FILELIST  = compile.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf $(OBJ_DIR)
